/* hw/mul_pkg.sv */
// Multiplier widths and types
package mul_pkg;

  // Operand and half-operand widths
  localparam int OPERAND_W = 16;
  localparam int HALF_W    = 8;

  // One 16-bit operand
  typedef logic [OPERAND_W-1:0] operand_t;

  // One half of an operand, fed to an 8 by 8 multiplier
  typedef logic [HALF_W-1:0] half_t;

  // Product of two halves
  typedef logic [2*HALF_W-1:0] partial_t;

  // Full 32-bit product
  typedef logic [2*OPERAND_W-1:0] product_t;

  // Operand pair as written by the processor, a in the upper half
  typedef struct packed {
    operand_t a;
    operand_t b;
  } operand_pair_t;

endpackage

/* hw/wb_pkg.sv */
// Wishbone bus types and register map
package wb_pkg;

  // Byte address and data word
  typedef logic [7:0]  addr_t;
  typedef logic [31:0] data_t;

  // Master to slave
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic  ack;
    data_t dat;
  } wb_rsp_t;

  // Register offsets
  localparam addr_t ADDR_OPERAND = 8'h00;
  localparam addr_t ADDR_RESULT  = 8'h04;
  localparam addr_t ADDR_STATUS  = 8'h08;

  // Slave FSM
  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    ACK
  } bus_state_t;

endpackage

/* hw/cla_adder.sv */
// Grouped carry-lookahead adder
`timescale 1ns/1ps

module cla_adder #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic [WIDTH-1:0] sum
);

  localparam int GROUPS = WIDTH / 4;

  logic [WIDTH-1:0]  p;
  logic [WIDTH-1:0]  g;
  logic [GROUPS-1:0] gp;
  logic [GROUPS-1:0] gg;
  logic [GROUPS-1:0] cc;

  assign p = a ^ b;
  assign g = a & b;

  // Group propagate and generate
  for (genvar k = 0; k < GROUPS; k++) begin : g_group
    assign gp[k] = &p[4*k +: 4];
    assign gg[k] = g[4*k+3]
                 | (p[4*k+3] & g[4*k+2])
                 | (p[4*k+3] & p[4*k+2] & g[4*k+1])
                 | (p[4*k+3] & p[4*k+2] & p[4*k+1] & g[4*k]);
  end

  // Each group carry is a flat sum of products, no ripple between groups
  always_comb begin
    logic term;
    cc[0] = 1'b0;
    for (int k = 1; k < GROUPS; k++) begin
      cc[k] = 1'b0;
      for (int j = 0; j < k; j++) begin
        term = gg[j];
        for (int m = j + 1; m < k; m++) begin
          term = term & gp[m];
        end
        cc[k] = cc[k] | term;
      end
    end
  end

  // Carries inside each group, then the sum bits
  for (genvar k = 0; k < GROUPS; k++) begin : g_sum
    logic [3:0] c;
    assign c[0] = cc[k];
    assign c[1] = g[4*k] | (p[4*k] & c[0]);
    assign c[2] = g[4*k+1] | (p[4*k+1] & g[4*k]) | (p[4*k+1] & p[4*k] & c[0]);
    assign c[3] = g[4*k+2]
                | (p[4*k+2] & g[4*k+1])
                | (p[4*k+2] & p[4*k+1] & g[4*k])
                | (p[4*k+2] & p[4*k+1] & p[4*k] & c[0]);
    assign sum[4*k +: 4] = p[4*k +: 4] ^ c;
  end

endmodule

/* hw/array_mul8.sv */
// Exact 8 by 8 array multiplier
`timescale 1ns/1ps

module array_mul8 (
  input  mul_pkg::half_t    a,
  input  mul_pkg::half_t    b,
  output mul_pkg::partial_t p
);

  localparam int N = mul_pkg::HALF_W;

  logic [N-1:0] pp [N];
  logic [N-1:0] s  [N];
  logic [N-2:0] c  [1:N-1];
  logic [N-1:0] rc;

  always_comb begin
    // AND grid, row i is a[i] times b
    for (int i = 0; i < N; i++) begin
      pp[i] = {N{a[i]}} & b;
    end

    s[0] = pp[0];

    // First row only needs half adders
    for (int j = 0; j < N-1; j++) begin
      s[1][j] = s[0][j+1] ^ pp[1][j];
      c[1][j] = s[0][j+1] & pp[1][j];
    end
    s[1][N-1] = pp[1][N-1];

    // Carry-save rows of full adders
    for (int i = 2; i < N; i++) begin
      for (int j = 0; j < N-1; j++) begin
        s[i][j] = s[i-1][j+1] ^ c[i-1][j] ^ pp[i][j];
        c[i][j] = (s[i-1][j+1] & c[i-1][j]) | (pp[i][j] & (s[i-1][j+1] ^ c[i-1][j]));
      end
      s[i][N-1] = pp[i][N-1];
    end

    for (int i = 0; i < N; i++) begin
      p[i] = s[i][0];
    end

    // Final ripple row merges the last sums and carries
    rc[0] = 1'b0;
    for (int j = 0; j < N-1; j++) begin
      p[N+j]  = s[N-1][j+1] ^ c[N-1][j] ^ rc[j];
      rc[j+1] = (s[N-1][j+1] & c[N-1][j]) | (rc[j] & (s[N-1][j+1] ^ c[N-1][j]));
    end
    p[2*N-1] = rc[N-1];
  end

endmodule

/* hw/word_fifo.sv */
// Synchronous word FIFO
`timescale 1ns/1ps

module word_fifo #(
  parameter int DEPTH = 4,
  localparam int AW = $clog2(DEPTH)
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          push,
  input  wb_pkg::data_t push_data,
  input  logic          pop,
  output wb_pkg::data_t pop_data,
  output logic          full,
  output logic          empty,
  output logic [AW:0]   count
);

  wb_pkg::data_t mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          do_push;
  logic          do_pop;

  assign full  = (count == (AW+1)'(DEPTH));
  assign empty = (count == '0);

  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Count stays put on a push and pop in the same cycle
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  assign pop_data = mem[rd_ptr];

endmodule

/* hw/mul16_pipe.sv */
// Two-stage 16 by 16 multiplier pipeline
`timescale 1ns/1ps

module mul16_pipe (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   op_empty,
  input  mul_pkg::operand_pair_t op_data,
  output logic                   op_pop,
  input  logic                   res_full,
  output logic                   res_push,
  output mul_pkg::product_t      res_data
);

  localparam int HW = mul_pkg::HALF_W;
  localparam int OW = mul_pkg::OPERAND_W;

  typedef struct packed {
    mul_pkg::partial_t hh;
    mul_pkg::partial_t lh;
    mul_pkg::partial_t hl;
    mul_pkg::partial_t ll;
  } partials_t;

  mul_pkg::half_t    a_lo;
  mul_pkg::half_t    a_hi;
  mul_pkg::half_t    b_lo;
  mul_pkg::half_t    b_hi;
  partials_t         pp_d;
  partials_t         pp_q;
  mul_pkg::product_t llhh;
  mul_pkg::product_t lh_shift;
  mul_pkg::product_t hl_shift;
  mul_pkg::product_t sum_mid;
  mul_pkg::product_t sum_d;
  mul_pkg::product_t sum_q;
  logic              s1_valid;
  logic              s2_valid;
  logic              stall;

  assign a_lo = op_data.a[HW-1:0];
  assign a_hi = op_data.a[OW-1:HW];
  assign b_lo = op_data.b[HW-1:0];
  assign b_hi = op_data.b[OW-1:HW];

  array_mul8 u_mul_ll (.a(a_lo), .b(b_lo), .p(pp_d.ll));
  array_mul8 u_mul_hl (.a(a_hi), .b(b_lo), .p(pp_d.hl));
  array_mul8 u_mul_lh (.a(a_lo), .b(b_hi), .p(pp_d.lh));
  array_mul8 u_mul_hh (.a(a_hi), .b(b_hi), .p(pp_d.hh));

  // High-high and low-low do not overlap, so they share one word
  assign llhh     = {pp_q.hh, pp_q.ll};
  assign lh_shift = {{HW{1'b0}}, pp_q.lh, {HW{1'b0}}};
  assign hl_shift = {{HW{1'b0}}, pp_q.hl, {HW{1'b0}}};

  cla_adder #(.WIDTH(2*OW)) u_add_lh (.a(llhh), .b(lh_shift), .sum(sum_mid));
  cla_adder #(.WIDTH(2*OW)) u_add_hl (.a(sum_mid), .b(hl_shift), .sum(sum_d));

  // Whole pipe freezes while the result FIFO refuses stage 2
  assign stall    = s2_valid & res_full;
  assign op_pop   = ~stall & ~op_empty;
  assign res_push = s2_valid & ~res_full;
  assign res_data = sum_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (!stall) begin
      s1_valid <= op_pop;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      pp_q  <= pp_d;
      sum_q <= sum_d;
    end
  end

endmodule

/* hw/wb_mul_regs.sv */
// Wishbone slave register block
`timescale 1ns/1ps

module wb_mul_regs #(
  parameter int DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  wb_pkg::wb_req_t        wb_req,
  output wb_pkg::wb_rsp_t        wb_rsp,
  input  logic                   op_full,
  output logic                   op_push,
  output mul_pkg::operand_pair_t op_data,
  input  logic                   res_empty,
  input  logic [$clog2(DEPTH):0] res_count,
  output logic                   res_pop,
  input  mul_pkg::product_t      res_data
);

  wb_pkg::bus_state_t state;
  wb_pkg::bus_state_t next_state;
  wb_pkg::data_t      status;
  wb_pkg::data_t      rd_next;
  wb_pkg::data_t      rd_dat;
  logic               req_valid;
  logic               is_op_wr;
  logic               is_res_rd;
  logic               is_status_rd;
  logic               blocked;
  logic               serve;

  assign req_valid    = wb_req.cyc & wb_req.stb;
  assign is_op_wr     = wb_req.we & (wb_req.adr == wb_pkg::ADDR_OPERAND);
  assign is_res_rd    = ~wb_req.we & (wb_req.adr == wb_pkg::ADDR_RESULT);
  assign is_status_rd = ~wb_req.we & (wb_req.adr == wb_pkg::ADDR_STATUS);

  // Access must wait for the FIFO it needs
  assign blocked = (is_op_wr & op_full) | (is_res_rd & res_empty);

  // No new access is taken while ack is out
  assign serve = req_valid & ~blocked & (state != wb_pkg::ACK);

  assign op_push = serve & is_op_wr;
  assign res_pop = serve & is_res_rd;
  assign op_data = mul_pkg::operand_pair_t'(wb_req.dat);

  assign status = {16'h0000, 8'(res_count), 6'b000000, ~res_empty, op_full};

  always_comb begin
    if (is_res_rd) begin
      rd_next = res_data;
    end else if (is_status_rd) begin
      rd_next = status;
    end else begin
      rd_next = '0;
    end
  end

  always_comb begin
    case (state)
      wb_pkg::IDLE, wb_pkg::WAIT: begin
        if (!req_valid) begin
          next_state = wb_pkg::IDLE;
        end else if (blocked) begin
          next_state = wb_pkg::WAIT;
        end else begin
          next_state = wb_pkg::ACK;
        end
      end
      default: next_state = wb_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= wb_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Read data captured on the edge that raises ack
  always_ff @(posedge clk) begin
    if (serve) begin
      rd_dat <= rd_next;
    end
  end

  assign wb_rsp.ack = (state == wb_pkg::ACK);
  assign wb_rsp.dat = rd_dat;

endmodule

/* hw/wb_mul_top.sv */
// Wishbone multiplier top level
`timescale 1ns/1ps

module wb_mul_top #(
  parameter int DEPTH = 4
) (
  input  logic            clk,
  input  logic            reset,
  input  wb_pkg::wb_req_t wb_req,
  output wb_pkg::wb_rsp_t wb_rsp
);

  logic                   op_full;
  logic                   op_empty;
  logic                   op_push;
  logic                   op_pop;
  mul_pkg::operand_pair_t op_in;
  mul_pkg::operand_pair_t op_out;

  logic                   res_full;
  logic                   res_empty;
  logic                   res_push;
  logic                   res_pop;
  logic [$clog2(DEPTH):0] res_count;
  mul_pkg::product_t      res_in;
  mul_pkg::product_t      res_out;

  wb_mul_regs #(.DEPTH(DEPTH)) u_regs (
    .clk       (clk),
    .reset     (reset),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .op_full   (op_full),
    .op_push   (op_push),
    .op_data   (op_in),
    .res_empty (res_empty),
    .res_count (res_count),
    .res_pop   (res_pop),
    .res_data  (res_out)
  );

  word_fifo #(.DEPTH(DEPTH)) u_operand_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (op_push),
    .push_data (op_in),
    .pop       (op_pop),
    .pop_data  (op_out),
    .full      (op_full),
    .empty     (op_empty),
    .count     ()
  );

  mul16_pipe u_pipe (
    .clk      (clk),
    .reset    (reset),
    .op_empty (op_empty),
    .op_data  (op_out),
    .op_pop   (op_pop),
    .res_full (res_full),
    .res_push (res_push),
    .res_data (res_in)
  );

  word_fifo #(.DEPTH(DEPTH)) u_result_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (res_push),
    .push_data (res_in),
    .pop       (res_pop),
    .pop_data  (res_out),
    .full      (res_full),
    .empty     (res_empty),
    .count     (res_count)
  );

endmodule

/* dv/wb_mul_chk.sv */
// Wishbone protocol assertions
`timescale 1ns/1ps

module wb_mul_chk (
  input logic            clk,
  input logic            reset,
  input wb_pkg::wb_req_t wb_req,
  input wb_pkg::wb_rsp_t wb_rsp
);

  // Failed assertion count
  int failures = 0;

  // Ack only inside an active cycle
  ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
    else begin
      $error("ack raised without cyc and stb");
      failures++;
    end

  ack_single: assert property (@(posedge clk) disable iff (reset)
    wb_rsp.ack |=> !wb_rsp.ack)
    else begin
      $error("ack held for two cycles");
      failures++;
    end

  // First cycle out of reset
  ack_after_reset: assert property (@(posedge clk) reset |=> !wb_rsp.ack)
    else begin
      $error("ack high right after reset");
      failures++;
    end

endmodule

bind wb_mul_top wb_mul_chk u_chk (
  .clk    (clk),
  .reset  (reset),
  .wb_req (wb_req),
  .wb_rsp (wb_rsp)
);

/* dv/tb_wb_mul.sv */
// Wishbone multiplier testbench
`timescale 1ns/1ps

module tb_wb_mul;

  localparam int DEPTH      = 4;
  localparam int NUM_RANDOM = 50;
  localparam int NUM_FILL   = 2 * DEPTH + 2;
  // Status read, 6 corner pairs, random pairs, fill test, late read test
  localparam int ACCESSES   = 1 + 12 + 2 * NUM_RANDOM + (2 * NUM_FILL + 2) + 3;
  localparam int LIMIT      = 20 * ACCESSES;

  logic            clk;
  logic            reset;
  wb_pkg::wb_req_t wb_req;
  wb_pkg::wb_rsp_t wb_rsp;
  int              cycles;
  int              checks;
  int              errors;
  integer          seed;

  wb_mul_top #(.DEPTH(DEPTH)) UUT (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Holds a request until ack, or gives up after window cycles if window is nonzero
  task automatic bus_cycle(input logic we, input wb_pkg::addr_t adr, input wb_pkg::data_t wdat,
                           input int window, output logic acked, output wb_pkg::data_t rdat);
    int waited;
    waited = 0;
    acked  = 1'b0;
    rdat   = '0;
    @(negedge clk);
    wb_req = {1'b1, 1'b1, we, adr, wdat};
    while (!acked && (window == 0 || waited < window)) begin
      @(negedge clk);
      waited++;
      if (wb_rsp.ack) begin
        acked = 1'b1;
        rdat  = wb_rsp.dat;
      end
    end
    // stb drops in the cycle after ack
    if (acked) begin
      @(negedge clk);
    end
    wb_req = '0;
  endtask

  task automatic wb_write(input wb_pkg::addr_t adr, input wb_pkg::data_t wdat);
    logic          acked;
    wb_pkg::data_t unused;
    bus_cycle(1'b1, adr, wdat, 0, acked, unused);
  endtask

  task automatic wb_read(input wb_pkg::addr_t adr, output wb_pkg::data_t rdat);
    logic acked;
    bus_cycle(1'b0, adr, '0, 0, acked, rdat);
  endtask

  task automatic expect_word(input wb_pkg::data_t got, input wb_pkg::data_t exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("%s finished with %0d errors", name, errors - errors_before);
  endtask

  // One pair in, its product back out
  task automatic multiply_and_check(input mul_pkg::operand_t a, input mul_pkg::operand_t b);
    wb_pkg::data_t got;
    wb_write(wb_pkg::ADDR_OPERAND, {a, b});
    wb_read(wb_pkg::ADDR_RESULT, got);
    expect_word(got, 32'(a) * 32'(b), $sformatf("product %h * %h", a, b));
  endtask

  task automatic status_after_reset();
    int            e0;
    wb_pkg::data_t got;
    e0 = errors;
    wb_read(wb_pkg::ADDR_STATUS, got);
    expect_word(got, '0, "STATUS after reset");
    report_test("status_after_reset", e0);
  endtask

  task automatic corner_products();
    int e0;
    e0 = errors;
    multiply_and_check(16'h0000, 16'h1234);
    multiply_and_check(16'hffff, 16'hffff);
    multiply_and_check(16'h00ff, 16'hff00);
    multiply_and_check(16'h0001, 16'hffff);
    multiply_and_check(16'hffff, 16'h0000);
    multiply_and_check(16'h8000, 16'h8000);
    report_test("corner_products", e0);
  endtask

  task automatic random_products();
    int e0;
    e0 = errors;
    repeat (NUM_RANDOM) begin
      multiply_and_check(16'($random(seed)), 16'($random(seed)));
    end
    report_test("random_products", e0);
  endtask

  // Writes until the operand FIFO refuses, then drains in order
  task automatic back_pressure();
    int                     e0;
    int                     written;
    logic                   acked;
    wb_pkg::data_t          got;
    mul_pkg::operand_pair_t pairs [NUM_FILL];
    e0      = errors;
    written = 0;
    acked   = 1'b1;
    for (int i = 0; i < NUM_FILL; i++) begin
      pairs[i] = mul_pkg::operand_pair_t'($random(seed));
    end
    // A write that stalls past the window stays pending
    while (acked && written < NUM_FILL) begin
      bus_cycle(1'b1, wb_pkg::ADDR_OPERAND, pairs[written], 10, acked, got);
      if (acked) begin
        written++;
      end
    end
    wb_read(wb_pkg::ADDR_STATUS, got);
    expect_word(got, (wb_pkg::data_t'(DEPTH) << 8) | 32'h3, "STATUS under back-pressure");
    for (int i = 0; i < NUM_FILL; i++) begin
      wb_read(wb_pkg::ADDR_RESULT, got);
      expect_word(got, 32'(pairs[i].a) * 32'(pairs[i].b), $sformatf("result %0d", i));
      if (written < NUM_FILL) begin
        wb_write(wb_pkg::ADDR_OPERAND, pairs[written]);
        written++;
      end
    end
    report_test("back_pressure", e0);
  endtask

  task automatic read_before_write();
    int            e0;
    logic          acked;
    wb_pkg::data_t got;
    e0 = errors;
    bus_cycle(1'b0, wb_pkg::ADDR_RESULT, '0, 10, acked, got);
    checks++;
    if (acked) begin
      errors++;
      $display("[ERROR] %0t: RESULT read was acknowledged with no product queued", $time);
    end
    multiply_and_check(16'h1234, 16'habcd);
    report_test("read_before_write", e0);
  endtask

  initial begin
    seed   = 10472;
    reset  = 1'b1;
    wb_req = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    status_after_reset();
    corner_products();
    random_products();
    back_pressure();
    read_before_write();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             UUT.u_chk.failures);
    if (errors == 0 && UUT.u_chk.failures == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
hw/mul_pkg.sv
hw/wb_pkg.sv
hw/cla_adder.sv
hw/array_mul8.sv
hw/word_fifo.sv
hw/mul16_pipe.sv
hw/wb_mul_regs.sv
hw/wb_mul_top.sv
dv/wb_mul_chk.sv
dv/tb_wb_mul.sv
